//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
TOP       := clint_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- design/axil_slave_port.sv
`timescale 1ns/1ps
`default_nettype none

module axil_slave_port (
    input  wire                                 clock,
    input  wire                                 reset,

    // Write address
    input  wire  [clint_pkg::addr_w-1:0]        awaddr_i,
    input  wire                                 awvalid_i,
    output logic                                awready_o,

    // Write data
    input  wire  [clint_pkg::data_w-1:0]        wdata_i,
    input  wire  [clint_pkg::data_w/8-1:0]      wstrb_i,
    input  wire                                 wvalid_i,
    output logic                                wready_o,

    // Write response
    output logic [1:0]                          bresp_o,
    output logic                                bvalid_o,
    input  wire                                 bready_i,

    // Read address
    input  wire  [clint_pkg::addr_w-1:0]        araddr_i,
    input  wire                                 arvalid_i,
    output logic                                arready_o,

    // Read data
    output logic [clint_pkg::data_w-1:0]        rdata_o,
    output logic [1:0]                          rresp_o,
    output logic                                rvalid_o,
    input  wire                                 rready_i,

    clint_reg_if.port                           bus
);

    clint_pkg::axil_state_e         state_q;

    logic                           ar_fire;
    logic                           aw_fire;
    logic                           ar_in_win;
    logic                           aw_in_win;

    // Response payload
    logic [clint_pkg::data_w-1:0]   rdata_q;
    logic [1:0]                     rresp_q;
    logic [1:0]                     bresp_q;

    // Window hit when the bits above the span match the base
    assign ar_in_win = (araddr_i & ~clint_pkg::clint_span_mask) == clint_pkg::clint_base;
    assign aw_in_win = (awaddr_i & ~clint_pkg::clint_span_mask) == clint_pkg::clint_base;

    // Reads always welcome in idle
    assign arready_o = (state_q == clint_pkg::idle);
    // AW and W only together, and AR wins a tie
    assign awready_o = (state_q == clint_pkg::idle) && !arvalid_i && wvalid_i;
    assign wready_o  = (state_q == clint_pkg::idle) && !arvalid_i && awvalid_i;

    assign ar_fire = arvalid_i && arready_o;
    assign aw_fire = awvalid_i && awready_o;

    // Register access, only for the window
    assign bus.req    = (ar_fire && ar_in_win) || (aw_fire && aw_in_win);
    assign bus.we     = aw_fire;
    assign bus.offset = ar_fire ? araddr_i[clint_pkg::offs_w-1:0]
                                : awaddr_i[clint_pkg::offs_w-1:0];
    assign bus.wdata  = wdata_i;
    assign bus.wstrb  = wstrb_i;

    // One transaction in flight
    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= clint_pkg::idle;
        end else begin
            case (state_q)
                clint_pkg::idle: begin
                    if (ar_fire) begin
                        state_q <= clint_pkg::read_resp;
                    end else if (aw_fire) begin
                        state_q <= clint_pkg::write_resp;
                    end
                end
                clint_pkg::read_resp: begin
                    if (rready_i) begin
                        state_q <= clint_pkg::idle;
                    end
                end
                clint_pkg::write_resp: begin
                    if (bready_i) begin
                        state_q <= clint_pkg::idle;
                    end
                end
                default: state_q <= clint_pkg::idle;
            endcase
        end
    end

    // Capture at the handshake edge, zero data on DECERR
    always_ff @(posedge clock) begin
        if (ar_fire) begin
            rdata_q <= ar_in_win ? bus.rdata : '0;
            rresp_q <= ar_in_win ? clint_pkg::resp_okay : clint_pkg::resp_decerr;
        end
        if (aw_fire) begin
            bresp_q <= aw_in_win ? clint_pkg::resp_okay : clint_pkg::resp_decerr;
        end
    end

    assign rvalid_o = (state_q == clint_pkg::read_resp);
    assign rdata_o  = rdata_q;
    assign rresp_o  = rresp_q;
    assign bvalid_o = (state_q == clint_pkg::write_resp);
    assign bresp_o  = bresp_q;

    // Read response holds steady under back-pressure
    a_rvalid_hold: assert property (@(posedge clock) disable iff (reset)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o))
        else $error("rvalid_o or read payload changed before rready_i");

    // Same for the write response
    a_bvalid_hold: assert property (@(posedge clock) disable iff (reset)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
        else $error("bvalid_o or bresp_o changed before bready_i");

    // No register access while a response is pending
    a_req_idle: assert property (@(posedge clock) disable iff (reset)
        bus.req |-> state_q == clint_pkg::idle)
        else $error("register req raised outside idle");

endmodule

`default_nettype wire

//--- design/clint_pkg.sv
`default_nettype none

package clint_pkg;

    // Bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // Offset width inside the 64 KiB window
    localparam int offs_w = 16;

    // Window base and the bits that select a register inside it
    localparam logic [addr_w-1:0] clint_base      = 32'h0200_0000;
    localparam logic [addr_w-1:0] clint_span_mask = 32'h0000_FFFF;

    // Register offsets
    localparam logic [offs_w-1:0] off_mtime_lo = 16'h0000;
    localparam logic [offs_w-1:0] off_mtime_hi = 16'h0004;
    localparam logic [offs_w-1:0] off_cmp_lo   = 16'h0008;
    localparam logic [offs_w-1:0] off_cmp_hi   = 16'h000C;
    localparam logic [offs_w-1:0] off_msip     = 16'h0010;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_decerr = 2'b11;

    // All ones keeps the timer interrupt quiet out of reset
    localparam logic [63:0] mtimecmp_reset = 64'hFFFF_FFFF_FFFF_FFFF;

    // Bus port states
    typedef enum logic [1:0] {
        idle       = 2'd0,
        read_resp  = 2'd1,
        write_resp = 2'd2
    } axil_state_e;

    // Timer load opcodes, one half at a time
    typedef enum logic [2:0] {
        wr_none     = 3'd0,
        wr_mtime_lo = 3'd1,
        wr_mtime_hi = 3'd2,
        wr_cmp_lo   = 3'd3,
        wr_cmp_hi   = 3'd4
    } timer_wr_e;

endpackage

`default_nettype wire

//--- design/clint_reg_if.sv
`timescale 1ns/1ps
`default_nettype none

// One register access, bus port to register file
interface clint_reg_if;

    // Single-cycle strobe, in-window accesses only
    logic                                req;
    logic                                we;
    logic [clint_pkg::offs_w-1:0]        offset;
    logic [clint_pkg::data_w-1:0]        wdata;
    logic [clint_pkg::data_w/8-1:0]      wstrb;

    // Read data, same cycle as req
    logic [clint_pkg::data_w-1:0]        rdata;

    // Bus side
    modport port (
        output req, we, offset, wdata, wstrb,
        input  rdata
    );

    // Register file side
    modport regs (
        input  req, we, offset, wdata, wstrb,
        output rdata
    );

endinterface

`default_nettype wire

//--- design/clint_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module clint_regfile (
    input  wire         clock,
    input  wire         reset,

    // Software interrupt straight from msip
    output logic        soft_irq_o,

    clint_reg_if.regs   bus,
    clint_timer_if.ctrl tmr
);

    logic                           msip_q;
    logic                           msip_wr;
    logic                           wr_en;

    // Current value at the offset, and the same value after strobes
    logic [clint_pkg::data_w-1:0]   cur_word;
    logic [clint_pkg::data_w-1:0]   merged_word;

    assign wr_en = bus.req && bus.we;

    // Read mux, unmapped offsets give zero
    always_comb begin : read_mux
        case (bus.offset)
            clint_pkg::off_mtime_lo: cur_word = tmr.mtime[31:0];
            clint_pkg::off_mtime_hi: cur_word = tmr.mtime[63:32];
            clint_pkg::off_cmp_lo:   cur_word = tmr.mtimecmp[31:0];
            clint_pkg::off_cmp_hi:   cur_word = tmr.mtimecmp[63:32];
            clint_pkg::off_msip:     cur_word = {31'd0, msip_q};
            default:                 cur_word = '0;
        endcase
    end

    assign bus.rdata = cur_word;

    // Byte lanes without a strobe keep the old value
    always_comb begin : strobe_merge
        for (int i = 0; i < clint_pkg::data_w / 8; i++) begin
            merged_word[8*i +: 8] = bus.wstrb[i] ? bus.wdata[8*i +: 8] : cur_word[8*i +: 8];
        end
    end

    assign tmr.wr_word = merged_word;

    // Write decode into a timer opcode or the msip bit
    always_comb begin : op_decode
        tmr.wr_op = clint_pkg::wr_none;
        msip_wr   = 1'b0;
        if (wr_en) begin
            case (bus.offset)
                clint_pkg::off_mtime_lo: tmr.wr_op = clint_pkg::wr_mtime_lo;
                clint_pkg::off_mtime_hi: tmr.wr_op = clint_pkg::wr_mtime_hi;
                clint_pkg::off_cmp_lo:   tmr.wr_op = clint_pkg::wr_cmp_lo;
                clint_pkg::off_cmp_hi:   tmr.wr_op = clint_pkg::wr_cmp_hi;
                clint_pkg::off_msip:     msip_wr   = 1'b1;
                // Unmapped, write dropped
                default: ;
            endcase
        end
    end

    // Only bit 0 is backed
    always_ff @(posedge clock) begin
        if (reset) begin
            msip_q <= 1'b0;
        end else if (msip_wr) begin
            msip_q <= merged_word[0];
        end
    end

    assign soft_irq_o = msip_q;

    // Timer never loads without a write access from the port
    a_no_stray_load: assert property (@(posedge clock) disable iff (reset)
        !(bus.req && bus.we) |-> tmr.wr_op == clint_pkg::wr_none)
        else $error("timer load issued without a register write");

endmodule

`default_nettype wire

//--- design/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
    input  wire             clock,
    input  wire             reset,

    // Registered mtime >= mtimecmp
    output logic            timer_irq_o,

    clint_timer_if.timer    tmr
);

    logic [63:0]    mtime_q;
    logic [63:0]    mtimecmp_q;
    logic           irq_q;
    logic           cmp_hit;

    // Free-running counter, a load takes the place of the increment
    always_ff @(posedge clock) begin
        if (reset) begin
            mtime_q <= '0;
        end else begin
            case (tmr.wr_op)
                clint_pkg::wr_mtime_lo: mtime_q <= {mtime_q[63:32], tmr.wr_word};
                clint_pkg::wr_mtime_hi: mtime_q <= {tmr.wr_word, mtime_q[31:0]};
                default:                mtime_q <= mtime_q + 64'd1;
            endcase
        end
    end

    // Compare register, one half per load
    always_ff @(posedge clock) begin
        if (reset) begin
            mtimecmp_q <= clint_pkg::mtimecmp_reset;
        end else begin
            case (tmr.wr_op)
                clint_pkg::wr_cmp_lo: mtimecmp_q <= {mtimecmp_q[63:32], tmr.wr_word};
                clint_pkg::wr_cmp_hi: mtimecmp_q <= {tmr.wr_word, mtimecmp_q[31:0]};
                default:              mtimecmp_q <= mtimecmp_q;
            endcase
        end
    end

    // Unsigned 64-bit compare
    assign cmp_hit = (mtime_q >= mtimecmp_q);

    // One cycle behind the counter values
    always_ff @(posedge clock) begin
        if (reset) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= cmp_hit;
        end
    end

    assign timer_irq_o  = irq_q;
    assign tmr.mtime    = mtime_q;
    assign tmr.mtimecmp = mtimecmp_q;

    // Interrupt lags the compare by exactly one clock
    a_irq_lag: assert property (@(posedge clock) disable iff (reset)
        1'b1 |=> timer_irq_o == $past(cmp_hit))
        else $error("timer_irq_o does not match previous compare");

endmodule

`default_nettype wire

//--- design/clint_timer_if.sv
`timescale 1ns/1ps
`default_nettype none

// Load commands down, counter values back up
interface clint_timer_if;

    // Load opcode and strobe-merged word
    clint_pkg::timer_wr_e           wr_op;
    logic [clint_pkg::data_w-1:0]   wr_word;

    // Current counter and compare values
    logic [63:0]                    mtime;
    logic [63:0]                    mtimecmp;

    // Register file side
    modport ctrl (
        output wr_op, wr_word,
        input  mtime, mtimecmp
    );

    // Timer side
    modport timer (
        input  wr_op, wr_word,
        output mtime, mtimecmp
    );

endinterface

`default_nettype wire

//--- design/clint_top.sv
`timescale 1ns/1ps
`default_nettype none

module clint_top (
    input  wire                                 clock,
    input  wire                                 reset,

    // AW channel
    input  wire  [clint_pkg::addr_w-1:0]        awaddr_i,
    input  wire                                 awvalid_i,
    output logic                                awready_o,

    // W channel
    input  wire  [clint_pkg::data_w-1:0]        wdata_i,
    input  wire  [clint_pkg::data_w/8-1:0]      wstrb_i,
    input  wire                                 wvalid_i,
    output logic                                wready_o,

    // B channel
    output logic [1:0]                          bresp_o,
    output logic                                bvalid_o,
    input  wire                                 bready_i,

    // AR channel
    input  wire  [clint_pkg::addr_w-1:0]        araddr_i,
    input  wire                                 arvalid_i,
    output logic                                arready_o,

    // R channel
    output logic [clint_pkg::data_w-1:0]        rdata_o,
    output logic [1:0]                          rresp_o,
    output logic                                rvalid_o,
    input  wire                                 rready_i,

    // Interrupts to the hart
    output logic                                timer_irq_o,
    output logic                                soft_irq_o
);

    // Port to register file
    clint_reg_if    reg_bus ();
    // Register file to timer
    clint_timer_if  tmr_bus ();

    axil_slave_port port_inst (
        .clock      (clock),
        .reset      (reset),
        .awaddr_i   (awaddr_i),
        .awvalid_i  (awvalid_i),
        .awready_o  (awready_o),
        .wdata_i    (wdata_i),
        .wstrb_i    (wstrb_i),
        .wvalid_i   (wvalid_i),
        .wready_o   (wready_o),
        .bresp_o    (bresp_o),
        .bvalid_o   (bvalid_o),
        .bready_i   (bready_i),
        .araddr_i   (araddr_i),
        .arvalid_i  (arvalid_i),
        .arready_o  (arready_o),
        .rdata_o    (rdata_o),
        .rresp_o    (rresp_o),
        .rvalid_o   (rvalid_o),
        .rready_i   (rready_i),
        .bus        (reg_bus.port)
    );

    clint_regfile regfile_inst (
        .clock      (clock),
        .reset      (reset),
        .soft_irq_o (soft_irq_o),
        .bus        (reg_bus.regs),
        .tmr        (tmr_bus.ctrl)
    );

    clint_timer timer_inst (
        .clock       (clock),
        .reset       (reset),
        .timer_irq_o (timer_irq_o),
        .tmr         (tmr_bus.timer)
    );

endmodule

`default_nettype wire

//--- files.f
+incdir+verif
design/clint_pkg.sv
design/clint_reg_if.sv
design/clint_timer_if.sv
design/axil_slave_port.sv
design/clint_regfile.sv
design/clint_timer.sv
design/clint_top.sv
verif/clint_tb.sv

//--- verif/clint_bus_tasks.svh
`ifndef CLINT_BUS_TASKS_SVH
`define CLINT_BUS_TASKS_SVH

// Exact compare of a sampled value
task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
        fail_now($sformatf("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp));
    end
endtask

// Counter value against its lower bound
task automatic check_min(input string name, input logic [63:0] got, input logic [63:0] low);
    assert (got >= low) else begin
        fail_now($sformatf("** Error at %0t: %s = 0x%0h, expected at least 0x%0h",
                           $time, name, got, low));
    end
endtask

// AR handshake, then R held for stall cycles before rready
task automatic axil_read(input logic [31:0] addr, input int stall,
                         output logic [31:0] data, output logic [1:0] resp);
    int n;
    n = 0;
    @(negedge clock);
    araddr_i  = addr;
    arvalid_i = 1'b1;
    // Ready is combinational, let it settle
    #1;
    while (!arready_o) begin
        n = n + 1;
        if (n > timeout_cycles) begin
            fail_now("read address handshake timed out");
        end
        @(negedge clock);
        #1;
    end
    // mtime the port captures on the coming edge
    sample_cyc = cyc;
    @(negedge clock);
    arvalid_i = 1'b0;
    n = 0;
    while (!rvalid_o) begin
        n = n + 1;
        if (n > timeout_cycles) begin
            fail_now("read response never arrived");
        end
        @(negedge clock);
    end
    data = rdata_o;
    resp = rresp_o;
    // Response must sit still while rready is low
    for (int i = 0; i < stall; i++) begin
        @(negedge clock);
        check_value("rvalid_o", 32'(rvalid_o), 32'd1);
        check_value("rdata_o", rdata_o, data);
        check_value("rresp_o", 32'(rresp_o), 32'(resp));
    end
    rready_i = 1'b1;
    @(negedge clock);
    rready_i = 1'b0;
endtask

// AW and W together, then B held for stall cycles before bready
task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, input int stall,
                          output logic [1:0] resp);
    int n;
    n = 0;
    @(negedge clock);
    awaddr_i  = addr;
    wdata_i   = data;
    wstrb_i   = strb;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    #1;
    while (!(awready_o && wready_o)) begin
        n = n + 1;
        if (n > timeout_cycles) begin
            fail_now("write address and data handshake timed out");
        end
        @(negedge clock);
        #1;
    end
    // Clock count just before the load edge
    write_cyc = cyc;
    @(negedge clock);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    n = 0;
    while (!bvalid_o) begin
        n = n + 1;
        if (n > timeout_cycles) begin
            fail_now("write response never arrived");
        end
        @(negedge clock);
    end
    resp = bresp_o;
    for (int i = 0; i < stall; i++) begin
        @(negedge clock);
        check_value("bvalid_o", 32'(bvalid_o), 32'd1);
        check_value("bresp_o", 32'(bresp_o), 32'(resp));
    end
    bready_i = 1'b1;
    @(negedge clock);
    bready_i = 1'b0;
endtask

// In-window write expected to succeed, model follows
task automatic write_reg(input logic [15:0] off, input logic [31:0] data,
                         input logic [3:0] strb, input int stall);
    logic [1:0] resp;
    axil_write(clint_pkg::clint_base | {16'd0, off}, data, strb, stall, resp);
    check_value("bresp_o", 32'(resp), 32'(clint_pkg::resp_okay));
    model_write(off, data, strb);
endtask

// In-window read compared with the model
task automatic read_check(input logic [15:0] off, input int stall);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(clint_pkg::clint_base | {16'd0, off}, stall, data, resp);
    check_value("rresp_o", 32'(resp), 32'(clint_pkg::resp_okay));
    check_value("rdata_o", data, model_read(off));
endtask

`endif

//--- verif/clint_tb.sv
`timescale 1ns/1ps
`default_nettype none

module clint_tb;

    localparam int          half_period    = 4;
    localparam int          reset_cycles   = 5;
    localparam int          timeout_cycles = 100;
    localparam int          irq_wait       = 60;
    localparam int          n_rand         = 24;
    localparam logic [31:0] seed           = 32'hee0d;

    logic        clock;
    logic        reset;
    logic [31:0] awaddr_i;
    logic        awvalid_i;
    logic        awready_o;
    logic [31:0] wdata_i;
    logic [3:0]  wstrb_i;
    logic        wvalid_i;
    logic        wready_o;
    logic [1:0]  bresp_o;
    logic        bvalid_o;
    logic        bready_i;
    logic [31:0] araddr_i;
    logic        arvalid_i;
    logic        arready_o;
    logic [31:0] rdata_o;
    logic [1:0]  rresp_o;
    logic        rvalid_o;
    logic        rready_i;
    logic        timer_irq_o;
    logic        soft_irq_o;

    // Model of compare and msip
    logic [63:0] model_cmp;
    logic        model_msip;
    // mtime bound, last written value and the clock count after it
    logic [63:0] base_val;
    longint      base_cyc;
    longint      cyc;
    longint      sample_cyc;
    longint      write_cyc;
    logic [31:0] rng;

    clint_top clint_top_inst (
        .clock       (clock),
        .reset       (reset),
        .awaddr_i    (awaddr_i),
        .awvalid_i   (awvalid_i),
        .awready_o   (awready_o),
        .wdata_i     (wdata_i),
        .wstrb_i     (wstrb_i),
        .wvalid_i    (wvalid_i),
        .wready_o    (wready_o),
        .bresp_o     (bresp_o),
        .bvalid_o    (bvalid_o),
        .bready_i    (bready_i),
        .araddr_i    (araddr_i),
        .arvalid_i   (arvalid_i),
        .arready_o   (arready_o),
        .rdata_o     (rdata_o),
        .rresp_o     (rresp_o),
        .rvalid_o    (rvalid_o),
        .rready_i    (rready_i),
        .timer_irq_o (timer_irq_o),
        .soft_irq_o  (soft_irq_o)
    );

    always #half_period clock = ~clock;

    // Edges since reset, equals mtime until it is written
    always @(posedge clock) begin
        if (reset) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Lanes without a strobe keep the old byte
    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            r[8*i +: 8] = strb[i] ? data[8*i +: 8] : old[8*i +: 8];
        end
        return r;
    endfunction

    // Expected read, mtime offsets not covered here
    function automatic logic [31:0] model_read(input logic [15:0] off);
        case (off)
            clint_pkg::off_cmp_lo: return model_cmp[31:0];
            clint_pkg::off_cmp_hi: return model_cmp[63:32];
            clint_pkg::off_msip:   return {31'd0, model_msip};
            default:               return 32'd0;
        endcase
    endfunction

    function automatic void model_write(input logic [15:0] off, input logic [31:0] data,
                                        input logic [3:0] strb);
        logic [31:0] merged;
        merged = merge_bytes(model_read(off), data, strb);
        case (off)
            clint_pkg::off_cmp_lo: model_cmp[31:0]  = merged;
            clint_pkg::off_cmp_hi: model_cmp[63:32] = merged;
            clint_pkg::off_msip:   model_msip       = merged[0];
            default: ;
        endcase
    endfunction

    // Smallest mtime the last read may return
    function automatic logic [63:0] mtime_bound();
        return base_val + 64'(sample_cyc - base_cyc);
    endfunction

    `include "clint_bus_tasks.svh"

    initial begin
        logic [31:0] data;
        logic [31:0] first;
        logic [31:0] addr;
        logic [1:0]  resp;
        logic [63:0] v;
        logic [63:0] cmp;
        logic [63:0] bound;
        logic [15:0] off;
        int          n;

        clock      = 1'b0;
        reset      = 1'b1;
        awaddr_i   = '0;
        awvalid_i  = 1'b0;
        wdata_i    = '0;
        wstrb_i    = '0;
        wvalid_i   = 1'b0;
        bready_i   = 1'b0;
        araddr_i   = '0;
        arvalid_i  = 1'b0;
        rready_i   = 1'b0;
        model_cmp  = clint_pkg::mtimecmp_reset;
        model_msip = 1'b0;
        base_val   = '0;
        base_cyc   = 0;
        sample_cyc = 0;
        write_cyc  = 0;
        rng        = seed;
        repeat (reset_cycles) @(negedge clock);
        reset = 1'b0;

        // Reset state, compare all ones, counter running
        check_value("timer_irq_o", 32'(timer_irq_o), 32'd0);
        check_value("soft_irq_o", 32'(soft_irq_o), 32'd0);
        read_check(clint_pkg::off_cmp_lo, 0);
        read_check(clint_pkg::off_cmp_hi, 0);
        axil_read(clint_pkg::clint_base | {16'd0, clint_pkg::off_mtime_lo}, 0, first, resp);
        check_min("mtime_lo", {32'd0, first}, mtime_bound());
        axil_read(clint_pkg::clint_base | {16'd0, clint_pkg::off_mtime_lo}, 0, data, resp);
        check_min("mtime_lo", {32'd0, data}, mtime_bound());
        assert (data > first) else begin
            fail_now("mtime did not advance between two reads");
        end

        // Random strobed writes with readback
        for (int i = 0; i < n_rand; i++) begin
            rng = xorshift(rng);
            case (rng[1:0])
                2'd0:    off = clint_pkg::off_cmp_lo;
                2'd1:    off = clint_pkg::off_cmp_hi;
                default: off = clint_pkg::off_msip;
            endcase
            rng = xorshift(rng);
            data = rng;
            rng = xorshift(rng);
            write_reg(off, data, rng[3:0], 0);
            read_check(off, 0);
        end

        // Software interrupt follows msip
        write_reg(clint_pkg::off_msip, 32'd1, 4'h1, 0);
        check_value("soft_irq_o", 32'(soft_irq_o), 32'd1);
        write_reg(clint_pkg::off_msip, 32'd0, 4'hF, 0);
        check_value("soft_irq_o", 32'(soft_irq_o), 32'd0);

        // Timer interrupt, top bits clear so nothing wraps
        rng = xorshift(rng);
        v[63:32] = {1'b0, rng[30:0]};
        rng = xorshift(rng);
        v[31:0] = {1'b0, rng[30:0]};
        cmp = v + 64'd40;
        write_reg(clint_pkg::off_cmp_hi, 32'hFFFF_FFFF, 4'hF, 0);
        write_reg(clint_pkg::off_mtime_lo, v[31:0], 4'hF, 0);
        write_reg(clint_pkg::off_mtime_hi, v[63:32], 4'hF, 0);
        base_val = v;
        base_cyc = write_cyc + 1;
        write_reg(clint_pkg::off_cmp_lo, cmp[31:0], 4'hF, 0);
        write_reg(clint_pkg::off_cmp_hi, cmp[63:32], 4'hF, 0);
        check_value("timer_irq_o", 32'(timer_irq_o), 32'd0);
        n = 0;
        while (!timer_irq_o) begin
            n = n + 1;
            if (n > irq_wait) begin
                fail_now("timer_irq_o did not rise within 60 cycles");
            end
            @(negedge clock);
        end
        axil_read(clint_pkg::clint_base | {16'd0, clint_pkg::off_mtime_lo}, 0, data, resp);
        bound = mtime_bound();
        check_min("mtime_lo", {32'd0, data}, {32'd0, bound[31:0]});
        write_reg(clint_pkg::off_cmp_hi, 32'hFFFF_FFFF, 4'hF, 0);
        n = 0;
        while (timer_irq_o) begin
            n = n + 1;
            if (n > irq_wait) begin
                fail_now("timer_irq_o stayed high after mtimecmp was raised");
            end
            @(negedge clock);
        end

        // Outside the window, then unmapped offsets inside it
        for (int i = 0; i < 8; i++) begin
            rng = xorshift(rng);
            addr = rng & ~clint_pkg::clint_span_mask;
            if (addr == clint_pkg::clint_base) begin
                addr = addr ^ 32'h8000_0000;
            end
            // Foreign base over a mapped offset so a leaked write would show
            case (rng[1:0])
                2'd0:    addr = addr | {16'd0, clint_pkg::off_cmp_lo};
                2'd1:    addr = addr | {16'd0, clint_pkg::off_cmp_hi};
                default: addr = addr | {16'd0, clint_pkg::off_msip};
            endcase
            axil_write(addr, ~model_read(addr[15:0]), 4'hF, 0, resp);
            check_value("bresp_o", 32'(resp), 32'(clint_pkg::resp_decerr));
            axil_read(addr, 0, data, resp);
            check_value("rresp_o", 32'(resp), 32'(clint_pkg::resp_decerr));
            check_value("rdata_o", data, 32'd0);
            rng = xorshift(rng);
            off = (rng[15:0] < 16'h0014) ? rng[15:0] + 16'h0014 : rng[15:0];
            write_reg(off, rng, 4'hF, 0);
            read_check(off, 0);
        end
        read_check(clint_pkg::off_cmp_lo, 0);
        read_check(clint_pkg::off_cmp_hi, 0);
        read_check(clint_pkg::off_msip, 0);

        // Back-pressure on both response channels
        for (int i = 0; i < 8; i++) begin
            rng = xorshift(rng);
            write_reg(clint_pkg::off_cmp_lo, rng, 4'hF, 1 + int'(rng[2:0]));
            rng = xorshift(rng);
            read_check(clint_pkg::off_cmp_lo, 1 + int'(rng[2:0]));
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
